/* hdl/arb_pkg.sv */
`default_nettype none

package arb_pkg;

   // Where a tag tree inserts register stages
   typedef enum logic [1:0] {
      DELAY_NONE      = 2'd0,
      // Root level is registered, then every second level below it
      DELAY_ALTERNATE = 2'd1,
      DELAY_ALL       = 2'd2
   } delay_conf_e;

   // Dispatcher FSM states
   typedef enum logic [1:0] {
      DISP_IDLE        = 2'd0,
      DISP_WAIT_WORKER = 2'd1,
      DISP_ISSUE       = 2'd2
   } disp_state_e;

endpackage

`default_nettype wire

/* hdl/job_pkg.sv */
`default_nettype none

package job_pkg;

   localparam int OPERAND_W = 16;
   localparam int JOB_ID_W  = 8;
   localparam int LEN_W     = 4;
   localparam int JOB_W     = 2 + JOB_ID_W + LEN_W + 2 * OPERAND_W;

   typedef enum logic [1:0] {
      OP_ADD = 2'd0,
      OP_SUB = 2'd1,
      OP_XOR = 2'd2,
      OP_MAX = 2'd3
   } opcode_e;

   // Packed job with the opcode in the top bits
   typedef struct packed {
      opcode_e               op;
      logic [JOB_ID_W-1:0]   id;
      logic [LEN_W-1:0]      len;
      logic [OPERAND_W-1:0]  a;
      logic [OPERAND_W-1:0]  b;
   } job_t;

   function automatic logic [OPERAND_W-1:0] calc_result(
      input opcode_e              op,
      input logic [OPERAND_W-1:0] a,
      input logic [OPERAND_W-1:0] b
   );
      case (op)
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_XOR:  return a ^ b;
         // Unsigned compare
         OP_MAX:  return (a > b) ? a : b;
         default: return '0;
      endcase
   endfunction

endpackage

`default_nettype wire

/* hdl/tree_node.sv */
`timescale 1ns/1ps
`default_nettype none

module tree_node #(
   parameter int TAG_W        = 2,
   parameter bit ENABLE_DELAY = 1'b0
) (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  logic [TAG_W-1:0] left_tag_i,
   input  logic             left_rdy_i,
   output logic             left_ack_o,
   input  logic [TAG_W-1:0] right_tag_i,
   input  logic             right_rdy_i,
   output logic             right_ack_o,
   output logic [TAG_W-1:0] tag_o,
   output logic             rdy_o,
   input  logic             ack_i
);

   logic any_rdy;
   logic pick_right;
   logic sel;
   logic steer;
   logic prio_right_q;
   logic locked_q;
   logic lock_sel_q;

   assign any_rdy = left_rdy_i | right_rdy_i;

   // Right child wins a tie only when it was not granted last
   assign pick_right = right_rdy_i & (~left_rdy_i | prio_right_q);

   // Hold the choice while it is on offer so the tag above stays stable
   assign sel = locked_q ? lock_sel_q : pick_right;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         prio_right_q <= 1'b0;
         locked_q     <= 1'b0;
         lock_sel_q   <= 1'b0;
      end else begin
         locked_q   <= any_rdy & ~ack_i;
         lock_sel_q <= sel;
         if (ack_i) begin
            prio_right_q <= ~steer;
         end
      end
   end

   if (ENABLE_DELAY) begin : g_reg
      logic [TAG_W-1:0] tag_q;
      logic             rdy_q;
      logic             sel_q;

      // Offer is withdrawn for one cycle after each grant
      always_ff @(posedge clk_i or negedge rst_n_i) begin
         if (!rst_n_i) begin
            rdy_q <= 1'b0;
            sel_q <= 1'b0;
         end else if (ack_i) begin
            rdy_q <= 1'b0;
         end else begin
            rdy_q <= any_rdy;
            sel_q <= sel;
         end
      end

      always_ff @(posedge clk_i) begin
         if (!ack_i) begin
            tag_q <= sel ? right_tag_i : left_tag_i;
         end
      end

      assign steer = sel_q;
      assign tag_o = tag_q;
      assign rdy_o = rdy_q;
   end else begin : g_comb
      assign steer = sel;
      assign tag_o = sel ? right_tag_i : left_tag_i;
      assign rdy_o = any_rdy;
   end

   assign left_ack_o  = ack_i & ~steer;
   assign right_ack_o = ack_i & steer;

endmodule

`default_nettype wire

/* hdl/tag_tree.sv */
`timescale 1ns/1ps
`default_nettype none

module tag_tree import arb_pkg::*; #(
   parameter int          N_WORKERS  = 4,
   parameter int          TAG_W      = 2,
   parameter delay_conf_e DELAY_CONF = DELAY_ALTERNATE
) (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic [N_WORKERS-1:0] rdy_leaf_i,
   output logic [N_WORKERS-1:0] ack_leaf_o,
   output logic [TAG_W-1:0]     tag_o,
   output logic                 rdy_o,
   input  logic                 ack_i
);

   if (N_WORKERS == 1) begin : g_single
      // A single leaf is its own root
      assign tag_o         = '0;
      assign rdy_o         = rdy_leaf_i[0];
      assign ack_leaf_o[0] = ack_i;
   end else begin : g_tree
      localparam int N_IDX = 2 * N_WORKERS - 1;

      // Heap order with the leaves first and the root last
      wire [TAG_W-1:0] tags [N_IDX];
      wire             rdys [N_IDX];
      wire             acks [N_IDX];

      for (genvar k = 0; k < N_WORKERS; k++) begin : g_leaf
         assign tags[k]       = TAG_W'(k);
         assign rdys[k]       = rdy_leaf_i[k];
         assign ack_leaf_o[k] = acks[k];
      end

      for (genvar k = 0; k < N_WORKERS - 1; k++) begin : g_node
         // Odd clog2 of the remaining span marks every second level from the root
         localparam bit NODE_DELAY = (DELAY_CONF == DELAY_ALL) ||
            ((DELAY_CONF == DELAY_ALTERNATE) && ($clog2(N_WORKERS - k) % 2 == 1));

         tree_node #(
            .TAG_W       (TAG_W),
            .ENABLE_DELAY(NODE_DELAY)
         ) u_node (
            .clk_i      (clk_i),
            .rst_n_i    (rst_n_i),
            .left_tag_i (tags[2*k]),
            .left_rdy_i (rdys[2*k]),
            .left_ack_o (acks[2*k]),
            .right_tag_i(tags[2*k+1]),
            .right_rdy_i(rdys[2*k+1]),
            .right_ack_o(acks[2*k+1]),
            .tag_o      (tags[N_WORKERS+k]),
            .rdy_o      (rdys[N_WORKERS+k]),
            .ack_i      (acks[N_WORKERS+k])
         );
      end

      assign tag_o            = tags[N_IDX-1];
      assign rdy_o            = rdys[N_IDX-1];
      assign acks[N_IDX-1]    = ack_i;
   end

endmodule

`default_nettype wire

/* hdl/job_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module job_fifo import job_pkg::*; #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  logic             push_i,
   input  logic [JOB_W-1:0] job_i,
   input  logic             pop_i,
   output logic [JOB_W-1:0] job_o,
   output logic             rdy_o,
   output logic             drop_o
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   logic [JOB_W-1:0] mem_q [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             full;
   logic             do_push;
   logic             do_pop;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full    = (count_q == CNT_W'(FIFO_DEPTH));
   assign do_push = push_i & ~full;
   assign do_pop  = pop_i & rdy_o;
   assign rdy_o   = (count_q != '0);
   assign job_o   = mem_q[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem_q[wr_ptr_q] <= job_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         drop_o   <= 1'b0;
      end else begin
         // A job arriving at a full queue is lost, only the strobe remains
         drop_o <= push_i & full;
         if (do_push) begin
            wr_ptr_q <= ptr_next(wr_ptr_q);
         end
         if (do_pop) begin
            rd_ptr_q <= ptr_next(rd_ptr_q);
         end
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/dispatch_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_fsm import arb_pkg::*, job_pkg::*; #(
   parameter int N_WORKERS = 4,
   parameter int TAG_W     = 2
) (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 fifo_rdy_i,
   input  logic [JOB_W-1:0]     fifo_job_i,
   output logic                 fifo_pop_o,
   input  logic                 idle_rdy_i,
   input  logic [TAG_W-1:0]     idle_tag_i,
   output logic                 idle_ack_o,
   output logic [N_WORKERS-1:0] start_o,
   output logic [JOB_W-1:0]     start_job_o
);

   disp_state_e      state_q;
   disp_state_e      state_d;
   logic [JOB_W-1:0] job_q;
   logic             issue;

   always_comb begin
      state_d = state_q;
      case (state_q)
         DISP_IDLE: begin
            if (fifo_rdy_i) begin
               state_d = idle_rdy_i ? DISP_ISSUE : DISP_WAIT_WORKER;
            end
         end
         DISP_WAIT_WORKER: begin
            if (idle_rdy_i) begin
               state_d = DISP_ISSUE;
            end
         end
         // Back to idle after every issue, so one job per two cycles at most
         DISP_ISSUE: state_d = DISP_IDLE;
         default:    state_d = DISP_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= DISP_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Head job is held here while a worker is found
   always_ff @(posedge clk_i) begin
      if (fifo_pop_o) begin
         job_q <= fifo_job_i;
      end
   end

   assign fifo_pop_o  = (state_q == DISP_IDLE) & fifo_rdy_i;
   assign issue       = (state_q == DISP_ISSUE);
   assign idle_ack_o  = issue;
   assign start_o     = issue ? (N_WORKERS'(1) << idle_tag_i) : '0;
   assign start_job_o = job_q;

endmodule

`default_nettype wire

/* hdl/work_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module work_timer import job_pkg::*; (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  logic             load_i,
   input  logic [LEN_W-1:0] len_i,
   output logic             expired_o
);

   logic [LEN_W-1:0] count_q;
   logic             running_q;

   assign expired_o = running_q & (count_q == '0);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         count_q   <= '0;
         running_q <= 1'b0;
      end else if (load_i) begin
         count_q   <= len_i;
         running_q <= 1'b1;
      end else if (running_q) begin
         // Stops itself once the zero count has been seen
         if (count_q == '0) begin
            running_q <= 1'b0;
         end else begin
            count_q <= count_q - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/worker.sv */
`timescale 1ns/1ps
`default_nettype none

module worker import job_pkg::*; (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 start_i,
   input  logic [JOB_W-1:0]     job_i,
   output logic                 idle_rdy_o,
   output logic                 done_rdy_o,
   input  logic                 done_ack_i,
   output logic [JOB_ID_W-1:0]  res_id_o,
   output logic [OPERAND_W-1:0] res_data_o
);

   typedef enum logic [1:0] {
      W_IDLE = 2'd0,
      W_BUSY = 2'd1,
      W_DONE = 2'd2
   } wstate_e;

   wstate_e              state_q;
   job_t                 job_in;
   job_t                 job_q;
   logic [OPERAND_W-1:0] res_q;
   logic                 accept;
   logic                 expired;

   assign job_in = job_t'(job_i);
   assign accept = start_i & (state_q == W_IDLE);

   work_timer u_timer (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .load_i   (accept),
      .len_i    (job_in.len),
      .expired_o(expired)
   );

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= W_IDLE;
      end else begin
         case (state_q)
            W_IDLE:  if (accept) state_q <= W_BUSY;
            W_BUSY:  if (expired) state_q <= W_DONE;
            W_DONE:  if (done_ack_i) state_q <= W_IDLE;
            default: state_q <= W_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         job_q <= job_in;
      end
      if (expired) begin
         res_q <= calc_result(job_q.op, job_q.a, job_q.b);
      end
   end

   assign idle_rdy_o = (state_q == W_IDLE);
   assign done_rdy_o = (state_q == W_DONE);
   assign res_id_o   = job_q.id;
   assign res_data_o = res_q;

endmodule

`default_nettype wire

/* hdl/result_drain.sv */
`timescale 1ns/1ps
`default_nettype none

module result_drain import job_pkg::*; #(
   parameter int N_WORKERS = 4,
   parameter int TAG_W     = 2
) (
   input  logic                                 clk_i,
   input  logic                                 rst_n_i,
   input  logic                                 done_rdy_i,
   input  logic [TAG_W-1:0]                     done_tag_i,
   output logic                                 done_ack_o,
   input  logic [N_WORKERS-1:0][JOB_ID_W-1:0]   worker_id_i,
   input  logic [N_WORKERS-1:0][OPERAND_W-1:0]  worker_data_i,
   output logic                                 res_valid_o,
   output logic [JOB_ID_W-1:0]                  res_id_o,
   output logic [OPERAND_W-1:0]                 res_data_o,
   output logic [TAG_W-1:0]                     res_worker_o
);

   // No back-pressure downstream, so any offer is taken at once
   assign done_ack_o = done_rdy_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         res_valid_o <= 1'b0;
      end else begin
         res_valid_o <= done_rdy_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (done_rdy_i) begin
         res_id_o     <= worker_id_i[done_tag_i];
         res_data_o   <= worker_data_i[done_tag_i];
         res_worker_o <= done_tag_i;
      end
   end

endmodule

`default_nettype wire

/* hdl/dispatch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_top import arb_pkg::*, job_pkg::*; #(
   parameter int          N_WORKERS  = 4,
   parameter int          FIFO_DEPTH = 4,
   parameter delay_conf_e DELAY_CONF = DELAY_ALTERNATE,
   localparam int         TAG_W      = (N_WORKERS > 1) ? $clog2(N_WORKERS) : 1
) (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 job_valid_i,
   input  logic [JOB_W-1:0]     job_i,
   output logic                 res_valid_o,
   output logic [JOB_ID_W-1:0]  res_id_o,
   output logic [OPERAND_W-1:0] res_data_o,
   output logic [TAG_W-1:0]     res_worker_o,
   output logic                 drop_o
);

   logic                                fifo_rdy;
   logic                                fifo_pop;
   logic [JOB_W-1:0]                    fifo_job;
   logic [N_WORKERS-1:0]                idle_rdy_leaf;
   logic [N_WORKERS-1:0]                idle_ack_leaf;
   logic                                idle_rdy;
   logic                                idle_ack;
   logic [TAG_W-1:0]                    idle_tag;
   logic [N_WORKERS-1:0]                start;
   logic [JOB_W-1:0]                    start_job;
   logic [N_WORKERS-1:0]                done_rdy_leaf;
   logic [N_WORKERS-1:0]                done_ack_leaf;
   logic                                done_rdy;
   logic                                done_ack;
   logic [TAG_W-1:0]                    done_tag;
   logic [N_WORKERS-1:0][JOB_ID_W-1:0]  worker_id;
   logic [N_WORKERS-1:0][OPERAND_W-1:0] worker_data;

   job_fifo #(
      .FIFO_DEPTH(FIFO_DEPTH)
   ) u_fifo (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .push_i (job_valid_i),
      .job_i  (job_i),
      .pop_i  (fifo_pop),
      .job_o  (fifo_job),
      .rdy_o  (fifo_rdy),
      .drop_o (drop_o)
   );

   dispatch_fsm #(
      .N_WORKERS(N_WORKERS),
      .TAG_W    (TAG_W)
   ) u_fsm (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .fifo_rdy_i (fifo_rdy),
      .fifo_job_i (fifo_job),
      .fifo_pop_o (fifo_pop),
      .idle_rdy_i (idle_rdy),
      .idle_tag_i (idle_tag),
      .idle_ack_o (idle_ack),
      .start_o    (start),
      .start_job_o(start_job)
   );

   // Idle tree picks the worker for the next job
   tag_tree #(
      .N_WORKERS (N_WORKERS),
      .TAG_W     (TAG_W),
      .DELAY_CONF(DELAY_CONF)
   ) u_idle_tree (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .rdy_leaf_i(idle_rdy_leaf),
      .ack_leaf_o(idle_ack_leaf),
      .tag_o     (idle_tag),
      .rdy_o     (idle_rdy),
      .ack_i     (idle_ack)
   );

   for (genvar k = 0; k < N_WORKERS; k++) begin : g_worker
      // Start reaches a worker only together with its idle grant
      worker u_worker (
         .clk_i     (clk_i),
         .rst_n_i   (rst_n_i),
         .start_i   (start[k] & idle_ack_leaf[k]),
         .job_i     (start_job),
         .idle_rdy_o(idle_rdy_leaf[k]),
         .done_rdy_o(done_rdy_leaf[k]),
         .done_ack_i(done_ack_leaf[k]),
         .res_id_o  (worker_id[k]),
         .res_data_o(worker_data[k])
      );
   end

   // Done tree picks which finished result leaves next
   tag_tree #(
      .N_WORKERS (N_WORKERS),
      .TAG_W     (TAG_W),
      .DELAY_CONF(DELAY_CONF)
   ) u_done_tree (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .rdy_leaf_i(done_rdy_leaf),
      .ack_leaf_o(done_ack_leaf),
      .tag_o     (done_tag),
      .rdy_o     (done_rdy),
      .ack_i     (done_ack)
   );

   result_drain #(
      .N_WORKERS(N_WORKERS),
      .TAG_W    (TAG_W)
   ) u_drain (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .done_rdy_i   (done_rdy),
      .done_tag_i   (done_tag),
      .done_ack_o   (done_ack),
      .worker_id_i  (worker_id),
      .worker_data_i(worker_data),
      .res_valid_o  (res_valid_o),
      .res_id_o     (res_id_o),
      .res_data_o   (res_data_o),
      .res_worker_o (res_worker_o)
   );

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS = 8
) (
   output logic clk_o
);

   initial clk_o = 1'b0;

   // Half period per toggle
   always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

`default_nettype wire

/* sim/dispatch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_tb import arb_pkg::*, job_pkg::*; ();

   localparam int N_WORKERS  = 3;
   localparam int FIFO_DEPTH = 4;
   localparam int TAG_W      = (N_WORKERS > 1) ? $clog2(N_WORKERS) : 1;
   localparam int N_RANDOM   = 200;
   localparam int N_BURSTS   = 3;
   localparam int BURST_LEN  = 10;
   localparam int N_SINGLE   = 16;
   localparam int N_JOBS     = N_RANDOM + N_BURSTS * BURST_LEN + N_WORKERS + N_SINGLE;
   localparam int JOB_CYCLES = 16 + FIFO_DEPTH + 8;
   localparam int TIMEOUT    = N_JOBS * JOB_CYCLES + 200;

   logic                 clk;
   logic                 rst_n;
   logic                 job_valid;
   logic [JOB_W-1:0]     job_data;
   logic                 res_valid;
   logic [JOB_ID_W-1:0]  res_id;
   logic [OPERAND_W-1:0] res_data;
   logic [TAG_W-1:0]     res_worker;
   logic                 drop;

   // Job model keyed by id
   logic [OPERAND_W-1:0] exp_data [int];
   int                   exp_len [int];
   int                   sent_cyc [int];

   int                   seed = 32'hcdb8;
   int                   cycle = 0;
   int                   next_id = 0;
   int                   err_cnt = 0;
   int                   err_start = 0;
   int                   pass_cnt = 0;
   int                   fail_cnt = 0;
   int                   sent_cnt = 0;
   int                   drop_cnt = 0;
   int                   res_cnt = 0;
   int                   unexpected_cnt = 0;
   logic [JOB_ID_W-1:0]  pushed_id = '0;
   logic [N_WORKERS-1:0] worker_seen = '0;
   logic [31:0]          r;
   string                test_name = "reset_state";

   tb_clk_gen #(
      .PERIOD_NS(8)
   ) u_clk (
      .clk_o(clk)
   );

   dispatch_top #(
      .N_WORKERS (N_WORKERS),
      .FIFO_DEPTH(FIFO_DEPTH),
      .DELAY_CONF(DELAY_ALTERNATE)
   ) UUT (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .job_valid_i (job_valid),
      .job_i       (job_data),
      .res_valid_o (res_valid),
      .res_id_o    (res_id),
      .res_data_o  (res_data),
      .res_worker_o(res_worker),
      .drop_o      (drop)
   );

   function automatic logic [OPERAND_W-1:0] expected_result(
      input opcode_e              op,
      input logic [OPERAND_W-1:0] a,
      input logic [OPERAND_W-1:0] b
   );
      logic [OPERAND_W-1:0] res;
      case (op)
         OP_ADD:  res = a + b;
         OP_SUB:  res = a - b;
         OP_XOR:  res = a ^ b;
         default: res = (a > b) ? a : b;
      endcase
      return res;
   endfunction

   task automatic report_mismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("[ERROR] %s: %s expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
      err_cnt++;
   endtask

   task automatic report_failure(input string msg);
      $display("%s: %s", test_name, msg);
      err_cnt++;
   endtask

   task automatic start_test(input string name);
      test_name = name;
      err_start = err_cnt;
   endtask

   task automatic clear_counts();
      sent_cnt = 0;
      drop_cnt = 0;
      res_cnt  = 0;
   endtask

   task automatic finish_test();
      if (err_cnt == err_start) begin
         $display("PASS %s", test_name);
         pass_cnt++;
      end else begin
         $display("[ERROR] %s: expected 0 failed checks, actual %0d",
                  test_name, err_cnt - err_start);
         fail_cnt++;
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         job_valid <= 1'b0;
      end
   endtask

   // Drives one strobe; the caller lowers it or sends the next job
   task automatic send_job(input opcode_e op, input logic [LEN_W-1:0] len);
      logic [OPERAND_W-1:0] a;
      logic [OPERAND_W-1:0] b;
      a = $random(seed);
      b = $random(seed);
      @(posedge clk);
      job_valid <= 1'b1;
      job_data  <= {op, JOB_ID_W'(next_id), len, a, b};
      exp_data[next_id] = expected_result(op, a, b);
      exp_len[next_id]  = len;
      // The strobe is seen in the cycle that starts at this edge
      sent_cyc[next_id] = cycle + 1;
      next_id++;
      sent_cnt++;
   endtask

   task automatic drain_model();
      int waited;
      int limit;
      waited = 0;
      limit  = (exp_data.num() + 1) * JOB_CYCLES + 50;
      idle_cycles(1);
      while (exp_data.num() != 0 && waited < limit) begin
         @(posedge clk);
         waited++;
      end
      if (exp_data.num() != 0) begin
         report_mismatch("jobs left unanswered", 0, exp_data.num());
      end
      // Let both trees settle before the next test
      idle_cycles(4);
   endtask

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   // Id of the job the queue sampled at this edge
   always @(posedge clk) begin
      if (job_valid) begin
         pushed_id <= job_data[JOB_W-3 -: JOB_ID_W];
      end
   end

   always @(negedge clk) begin : monitor
      int id;
      if (res_valid) begin
         res_cnt++;
         id = int'(res_id);
         if (res_worker >= N_WORKERS) begin
            report_failure("result carries a worker tag outside the worker range");
         end else begin
            worker_seen[res_worker] = 1'b1;
         end
         if (!exp_data.exists(id)) begin
            unexpected_cnt++;
            report_failure($sformatf("result id %0d was never accepted or already answered",
                                     id));
         end else begin
            if (res_data !== exp_data[id]) begin
               report_mismatch($sformatf("result of id %0d", id), exp_data[id], res_data);
            end
            if (cycle - sent_cyc[id] < exp_len[id] + 1) begin
               $display("[ERROR] %s: latency of id %0d expected at least %0d, actual %0d",
                        test_name, id, exp_len[id] + 1, cycle - sent_cyc[id]);
               err_cnt++;
            end
            exp_data.delete(id);
            exp_len.delete(id);
            sent_cyc.delete(id);
         end
      end
      if (drop) begin
         drop_cnt++;
         id = int'(pushed_id);
         if (!exp_data.exists(id)) begin
            report_failure($sformatf("drop strobe for id %0d which is not in the model", id));
         end else begin
            // The dropped job itself is still in the model here
            if (exp_data.num() - 1 < FIFO_DEPTH) begin
               report_failure("job dropped while the queue could not have been full");
            end
            exp_data.delete(id);
            exp_len.delete(id);
            sent_cyc.delete(id);
         end
      end
   end

   always @(posedge clk) begin
      if (cycle >= TIMEOUT) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
         $display("Test FAILED");
         $finish;
      end
   end

   initial begin
      rst_n     = 1'b0;
      job_valid = 1'b0;
      job_data  = '0;

      start_test("reset_state");
      repeat (8) begin
         @(negedge clk);
         if (res_valid || drop) begin
            report_failure("output strobe raised during reset");
         end
      end
      @(posedge clk);
      rst_n <= 1'b1;
      repeat (2) begin
         @(negedge clk);
         if (res_valid || drop) begin
            report_failure("output strobe raised right after reset");
         end
      end
      finish_test();

      start_test("opcode_results");
      clear_counts();
      unexpected_cnt = 0;
      for (int i = 0; i < N_RANDOM; i++) begin
         while (exp_data.num() >= FIFO_DEPTH) begin
            idle_cycles(1);
         end
         r = $random(seed);
         send_job(opcode_e'(r[1:0]), r[5:2]);
         idle_cycles(1 + int'(r[7:6]));
      end
      drain_model();
      finish_test();

      // Covers the traffic of the previous test
      start_test("completeness");
      if (exp_data.num() != 0) begin
         report_mismatch("model entries after drain", 0, exp_data.num());
      end
      if (unexpected_cnt != 0) begin
         report_mismatch("repeated or unknown result ids", 0, unexpected_cnt);
      end
      if (res_cnt != sent_cnt - drop_cnt) begin
         report_mismatch("results for accepted jobs", sent_cnt - drop_cnt, res_cnt);
      end
      finish_test();

      start_test("drop_accounting");
      clear_counts();
      for (int k = 0; k < N_BURSTS; k++) begin
         for (int i = 0; i < BURST_LEN; i++) begin
            r = $random(seed);
            send_job(opcode_e'(r[1:0]), LEN_W'(12 + int'(r[3:2])));
         end
         drain_model();
      end
      if (drop_cnt + res_cnt != sent_cnt) begin
         report_mismatch("drops plus results", sent_cnt, drop_cnt + res_cnt);
      end
      finish_test();

      start_test("worker_spread");
      clear_counts();
      worker_seen = '0;
      for (int i = 0; i < N_WORKERS; i++) begin
         r = $random(seed);
         send_job(opcode_e'(r[1:0]), LEN_W'(15));
      end
      drain_model();
      if (worker_seen != {N_WORKERS{1'b1}}) begin
         report_mismatch("workers seen", {N_WORKERS{1'b1}}, worker_seen);
      end
      finish_test();

      // Latency itself is checked by the monitor on every result
      start_test("min_latency");
      clear_counts();
      for (int i = 0; i < N_SINGLE; i++) begin
         r = $random(seed);
         send_job(opcode_e'(r[1:0]), r[5:2]);
         drain_model();
      end
      if (res_cnt != N_SINGLE) begin
         report_mismatch("results", N_SINGLE, res_cnt);
      end
      finish_test();

      $display("Summary: %0d tests passed, %0d tests failed, %0d failed checks",
               pass_cnt, fail_cnt, err_cnt);
      if (fail_cnt == 0 && err_cnt == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
hdl/arb_pkg.sv
hdl/job_pkg.sv
hdl/tree_node.sv
hdl/tag_tree.sv
hdl/job_fifo.sv
hdl/dispatch_fsm.sv
hdl/work_timer.sv
hdl/worker.sv
hdl/result_drain.sv
hdl/dispatch_top.sv
sim/tb_clk_gen.sv
sim/dispatch_tb.sv

/* Bender.yml */
package:
  name: job_dispatch

sources:
  - hdl/arb_pkg.sv
  - hdl/job_pkg.sv
  - hdl/tree_node.sv
  - hdl/tag_tree.sv
  - hdl/job_fifo.sv
  - hdl/dispatch_fsm.sv
  - hdl/work_timer.sv
  - hdl/worker.sv
  - hdl/result_drain.sv
  - hdl/dispatch_top.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/dispatch_tb.sv
